// File: include/execute_params.svh
`ifndef EXECUTE_PARAMS_SVH
`define EXECUTE_PARAMS_SVH

`define DATA_WIDTH          32
`define ADDRESS_WIDTH       32
`define REG_FILE_ADDR_WIDTH 5

// alu function codes
`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_AND 3'd2
`define ALU_OR  3'd3
`define ALU_XOR 3'd4
`define ALU_SLT 3'd5 // signed compare
`define ALU_SLL 3'd6
`define ALU_SRL 3'd7

`define RES_ALU 2'd0 // writeback select
`define RES_MEM 2'd1
`define RES_PC4 2'd2

`endif

// File: logic/execute_pkg.sv
`default_nettype none

`include "execute_params.svh"

package execute_pkg;

    // operand or result word
    typedef logic [`DATA_WIDTH-1:0] data_t;

    typedef logic [`ADDRESS_WIDTH-1:0] addr_t; // program counter value

    // register file index
    typedef logic [`REG_FILE_ADDR_WIDTH-1:0] reg_addr_t;

    typedef logic [2:0] alu_ctrl_t;   // alu function code
    typedef logic [1:0] result_src_t; // writeback select

endpackage

`default_nettype wire

// File: logic/pipeline_reg_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "execute_params.svh"

module pipeline_reg_execute
    import execute_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  clr,

    // control from decode
    input  wire logic        regwrited,
    input  wire result_src_t resultsrcd,
    input  wire logic        memwrited,
    input  wire logic        jumpd,
    input  wire logic        branchd,
    input  wire alu_ctrl_t   alucontrold,
    input  wire logic        alusrcd,
    input  wire logic        jalrd,

    // data from decode
    input  wire data_t       rd1d,
    input  wire data_t       rd2d,
    input  wire addr_t       pcd,
    input  wire reg_addr_t   rs1d,
    input  wire reg_addr_t   rs2d,
    input  wire reg_addr_t   rdd,
    input  wire data_t       immextd,
    input  wire addr_t       pcplus4d,

    output logic             regwritee,
    output result_src_t      resultsrce,
    output logic             memwritee,
    output logic             jumpe,
    output logic             branche,
    output alu_ctrl_t        alucontrole,
    output logic             alusrce,
    output logic             jalre,

    output data_t            rd1e,
    output data_t            rd2e,
    output addr_t            pce,
    output reg_addr_t        rs1e,
    output reg_addr_t        rs2e,
    output reg_addr_t        rde,
    output data_t            immexte,
    output addr_t            pcplus4e
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regwritee   <= 1'b0;
            resultsrce  <= result_src_t'(0);
            memwritee   <= 1'b0;
            jumpe       <= 1'b0;
            branche     <= 1'b0;
            alucontrole <= alu_ctrl_t'(0);
            alusrce     <= 1'b0;
            jalre       <= 1'b0;
            rd1e        <= data_t'(0);
            rd2e        <= data_t'(0);
            pce         <= addr_t'(0);
            rs1e        <= reg_addr_t'(0);
            rs2e        <= reg_addr_t'(0);
            rde         <= reg_addr_t'(0);
            immexte     <= data_t'(0);
            pcplus4e    <= addr_t'(0);
        end else if (clr) begin // clr is the synchronous flush
            regwritee   <= 1'b0;
            resultsrce  <= result_src_t'(0);
            memwritee   <= 1'b0;
            jumpe       <= 1'b0;
            branche     <= 1'b0;
            alucontrole <= alu_ctrl_t'(0);
            alusrce     <= 1'b0;
            jalre       <= 1'b0;
            rd1e        <= data_t'(0);
            rd2e        <= data_t'(0);
            pce         <= addr_t'(0);
            rs1e        <= reg_addr_t'(0);
            rs2e        <= reg_addr_t'(0);
            rde         <= reg_addr_t'(0);
            immexte     <= data_t'(0);
            pcplus4e    <= addr_t'(0);
        end else begin
            regwritee   <= regwrited;
            resultsrce  <= resultsrcd;
            memwritee   <= memwrited;
            jumpe       <= jumpd;
            branche     <= branchd;
            alucontrole <= alucontrold;
            alusrce     <= alusrcd;
            jalre       <= jalrd;
            rd1e        <= rd1d;
            rd2e        <= rd2d;
            pce         <= pcd;
            rs1e        <= rs1d;
            rs2e        <= rs2d;
            rde         <= rdd;
            immexte     <= immextd;
            pcplus4e    <= pcplus4d;
        end
    end

endmodule

`default_nettype wire

// File: logic/execute_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "execute_params.svh"

module execute_alu
    import execute_pkg::*;
(
    input  wire data_t      rd1e,
    input  wire data_t      rd2e,
    input  wire data_t      immexte,
    input  wire logic       alusrce,
    input  wire alu_ctrl_t  alucontrole,
    output data_t           aluresulte
);

    data_t     srcb;
    logic [4:0] shamt;

    assign srcb  = alusrce ? immexte : rd2e; // immediate forms
    assign shamt = srcb[4:0];

    always_comb begin
        case (alucontrole)
            `ALU_ADD: aluresulte = rd1e + srcb;
            `ALU_SUB: aluresulte = rd1e - srcb;
            `ALU_AND: aluresulte = rd1e & srcb;
            `ALU_OR:  aluresulte = rd1e | srcb;
            `ALU_XOR: aluresulte = rd1e ^ srcb;
            `ALU_SLT: begin
                // signed less-than, zero extended
                aluresulte = data_t'($signed(rd1e) < $signed(srcb));
            end
            `ALU_SLL: aluresulte = rd1e << shamt;
            `ALU_SRL: aluresulte = rd1e >> shamt; // logical
            default:  aluresulte = data_t'(0);
        endcase
    end

endmodule

`default_nettype wire

// File: logic/branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

`include "execute_params.svh"

module branch_resolve
    import execute_pkg::*;
(
    input  wire addr_t  pce,
    input  wire data_t  rd1e,
    input  wire data_t  rd2e,
    input  wire data_t  immexte,
    input  wire logic   jalre,
    output addr_t       pctargete,
    output logic        takene
);

    addr_t base;
    addr_t sum;

    // jalr is register relative, everything else pc relative
    assign base = jalre ? addr_t'(rd1e) : pce;
    assign sum  = base + addr_t'(immexte);

    assign pctargete = jalre ? {sum[`ADDRESS_WIDTH-1:1], 1'b0} : sum; // jalr lsb cleared

    assign takene = (rd1e == rd2e); // beq only

endmodule

`default_nettype wire

// File: logic/pipeline_reg_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "execute_params.svh"

module pipeline_reg_memory
    import execute_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,

    input  wire logic        jumpe,
    input  wire logic        branche,
    input  wire logic        takene,
    input  wire logic        regwritee,
    input  wire logic        memwritee,
    input  wire result_src_t resultsrce,
    input  wire data_t       aluresulte,
    input  wire data_t       rd2e,
    input  wire reg_addr_t   rde,
    input  wire addr_t       pcplus4e,

    output logic        pcsrce,   // redirect to fetch
    output logic        regwritem,
    output logic        memwritem,
    output result_src_t resultsrcm,
    output data_t       aluresultm,
    output data_t       writedatam,
    output reg_addr_t   rdm,
    output addr_t       pcplus4m
);

    // taken beq or any jump
    assign pcsrce = jumpe | (branche & takene);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regwritem  <= 1'b0;
            memwritem  <= 1'b0;
            resultsrcm <= result_src_t'(0);
            aluresultm <= data_t'(0);
            writedatam <= data_t'(0);
            rdm        <= reg_addr_t'(0);
            pcplus4m   <= addr_t'(0);
        end else begin
            regwritem  <= regwritee;
            memwritem  <= memwritee;
            resultsrcm <= resultsrce;
            aluresultm <= aluresulte;
            writedatam <= rd2e;     // store data
            rdm        <= rde;
            pcplus4m   <= pcplus4e; // for jal/jalr link
        end
    end

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "execute_params.svh"

module execute_stage
    import execute_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        clr,

    input  wire logic        regwrited,
    input  wire result_src_t resultsrcd,
    input  wire logic        memwrited,
    input  wire logic        jumpd,
    input  wire logic        branchd,
    input  wire alu_ctrl_t   alucontrold,
    input  wire logic        alusrcd,
    input  wire logic        jalrd,

    input  wire data_t       rd1d,
    input  wire data_t       rd2d,
    input  wire addr_t       pcd,
    input  wire reg_addr_t   rs1d,
    input  wire reg_addr_t   rs2d,
    input  wire reg_addr_t   rdd,
    input  wire data_t       immextd,
    input  wire addr_t       pcplus4d,

    // toward hazard unit
    output reg_addr_t   rs1e,
    output reg_addr_t   rs2e,
    output reg_addr_t   rde,

    output logic        pcsrce,
    output addr_t       pctargete,

    output logic        regwritem,
    output result_src_t resultsrcm,
    output logic        memwritem,
    output data_t       aluresultm,
    output data_t       writedatam,
    output reg_addr_t   rdm,
    output addr_t       pcplus4m
);

    logic        regwritee;
    result_src_t resultsrce;
    logic        memwritee;
    logic        jumpe;
    logic        branche;
    alu_ctrl_t   alucontrole;
    logic        alusrce;
    logic        jalre;
    data_t       rd1e;
    data_t       rd2e;
    addr_t       pce;
    data_t       immexte;
    addr_t       pcplus4e;
    data_t       aluresulte;
    logic        takene;

    pipeline_reg_execute u_pipeline_reg_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .clr         (clr),
        .regwrited   (regwrited),
        .resultsrcd  (resultsrcd),
        .memwrited   (memwrited),
        .jumpd       (jumpd),
        .branchd     (branchd),
        .alucontrold (alucontrold),
        .alusrcd     (alusrcd),
        .jalrd       (jalrd),
        .rd1d        (rd1d),
        .rd2d        (rd2d),
        .pcd         (pcd),
        .rs1d        (rs1d),
        .rs2d        (rs2d),
        .rdd         (rdd),
        .immextd     (immextd),
        .pcplus4d    (pcplus4d),
        .regwritee   (regwritee),
        .resultsrce  (resultsrce),
        .memwritee   (memwritee),
        .jumpe       (jumpe),
        .branche     (branche),
        .alucontrole (alucontrole),
        .alusrce     (alusrce),
        .jalre       (jalre),
        .rd1e        (rd1e),
        .rd2e        (rd2e),
        .pce         (pce),
        .rs1e        (rs1e),
        .rs2e        (rs2e),
        .rde         (rde),
        .immexte     (immexte),
        .pcplus4e    (pcplus4e)
    );

    execute_alu u_execute_alu (
        .rd1e        (rd1e),
        .rd2e        (rd2e),
        .immexte     (immexte),
        .alusrce     (alusrce),
        .alucontrole (alucontrole),
        .aluresulte  (aluresulte)
    );

    // runs in parallel with the alu
    branch_resolve u_branch_resolve (
        .pce       (pce),
        .rd1e      (rd1e),
        .rd2e      (rd2e),
        .immexte   (immexte),
        .jalre     (jalre),
        .pctargete (pctargete),
        .takene    (takene)
    );

    pipeline_reg_memory u_pipeline_reg_memory (
        .clk        (clk),
        .rst_n      (rst_n),
        .jumpe      (jumpe),
        .branche    (branche),
        .takene     (takene),
        .regwritee  (regwritee),
        .memwritee  (memwritee),
        .resultsrce (resultsrce),
        .aluresulte (aluresulte),
        .rd2e       (rd2e),
        .rde        (rde),
        .pcplus4e   (pcplus4e),
        .pcsrce     (pcsrce),
        .regwritem  (regwritem),
        .memwritem  (memwritem),
        .resultsrcm (resultsrcm),
        .aluresultm (aluresultm),
        .writedatam (writedatam),
        .rdm        (rdm),
        .pcplus4m   (pcplus4m)
    );

endmodule

`default_nettype wire

// File: dv/execute_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "execute_params.svh"

module execute_stage_checker
    import execute_pkg::*;
(
    input wire logic  clk,
    input wire logic  rst_n,
    input wire logic  clr,
    input wire logic  regwritee,
    input wire logic  memwritee,
    input wire logic  jumpe,
    input wire logic  branche,
    input wire logic  jalre,
    input wire logic  pcsrce,
    input wire addr_t pctargete,
    input wire logic  regwritem
);

    // flush leaves a bubble in execute
    assert property (@(posedge clk) disable iff (!rst_n)
        clr |=> (!regwritee && !memwritee && !jumpe && !branche))
        else $error("execute controls not cleared after flush");

    assert property (@(posedge clk) disable iff (!rst_n)
        pcsrce |-> (jumpe || branche))
        else $error("redirect raised without jump or branch");

    assert property (@(posedge clk) disable iff (!rst_n)
        jalre |-> !pctargete[0])
        else $error("jalr target has bit 0 set");

    assert property (@(posedge clk) disable iff (!rst_n)
        regwritem == $past(regwritee))
        else $error("regwritem does not follow regwritee");

endmodule

`default_nettype wire

// File: dv/execute_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "execute_params.svh"

module execute_stage_tb
    import execute_pkg::*;
;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_VECTORS = 600;

    // one decode bundle as the model tracks it
    typedef struct packed {
        logic        regwrite;
        result_src_t resultsrc;
        logic        memwrite;
        logic        jump;
        logic        branch;
        alu_ctrl_t   alucontrol;
        logic        alusrc;
        logic        jalr;
        data_t       rd1;
        data_t       rd2;
        addr_t       pc;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        data_t       immext;
        addr_t       pcplus4;
    } vec_t;

    logic clk = 1'b0;
    logic rst_n;
    logic clr;

    logic        regwrited;
    result_src_t resultsrcd;
    logic        memwrited;
    logic        jumpd;
    logic        branchd;
    alu_ctrl_t   alucontrold;
    logic        alusrcd;
    logic        jalrd;
    data_t       rd1d;
    data_t       rd2d;
    addr_t       pcd;
    reg_addr_t   rs1d;
    reg_addr_t   rs2d;
    reg_addr_t   rdd;
    data_t       immextd;
    addr_t       pcplus4d;

    reg_addr_t   rs1e;
    reg_addr_t   rs2e;
    reg_addr_t   rde;
    logic        pcsrce;
    addr_t       pctargete;
    logic        regwritem;
    result_src_t resultsrcm;
    logic        memwritem;
    data_t       aluresultm;
    data_t       writedatam;
    reg_addr_t   rdm;
    addr_t       pcplus4m;

    integer seed = 89446;
    int     checks = 0;
    vec_t   pipe[$]; // [0] is in memory stage, [1] in execute

    execute_stage u_execute_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .clr         (clr),
        .regwrited   (regwrited),
        .resultsrcd  (resultsrcd),
        .memwrited   (memwrited),
        .jumpd       (jumpd),
        .branchd     (branchd),
        .alucontrold (alucontrold),
        .alusrcd     (alusrcd),
        .jalrd       (jalrd),
        .rd1d        (rd1d),
        .rd2d        (rd2d),
        .pcd         (pcd),
        .rs1d        (rs1d),
        .rs2d        (rs2d),
        .rdd         (rdd),
        .immextd     (immextd),
        .pcplus4d    (pcplus4d),
        .rs1e        (rs1e),
        .rs2e        (rs2e),
        .rde         (rde),
        .pcsrce      (pcsrce),
        .pctargete   (pctargete),
        .regwritem   (regwritem),
        .resultsrcm  (resultsrcm),
        .memwritem   (memwritem),
        .aluresultm  (aluresultm),
        .writedatam  (writedatam),
        .rdm         (rdm),
        .pcplus4m    (pcplus4m)
    );

    bind execute_stage execute_stage_checker u_execute_stage_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .clr       (clr),
        .regwritee (regwritee),
        .memwritee (memwritee),
        .jumpe     (jumpe),
        .branche   (branche),
        .jalre     (jalre),
        .pcsrce    (pcsrce),
        .pctargete (pctargete),
        .regwritem (regwritem)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic data_t ref_alu(input alu_ctrl_t op, input data_t a, input data_t b);
        data_t res;
        logic  lt;
        res = '0;
        case (op)
            `ALU_ADD: res = a + b;
            `ALU_SUB: res = a - b;
            `ALU_AND: res = a & b;
            `ALU_OR:  res = a | b;
            `ALU_XOR: res = a ^ b;
            `ALU_SLT: begin
                // differing signs decide on their own
                if (a[`DATA_WIDTH-1] != b[`DATA_WIDTH-1])
                    lt = a[`DATA_WIDTH-1];
                else
                    lt = (a < b);
                res[0] = lt;
            end
            `ALU_SLL: res = a << b[4:0];
            default:  res = a >> b[4:0]; // srl
        endcase
        return res;
    endfunction

    function automatic addr_t ref_target(input vec_t v);
        addr_t t;
        if (v.jalr) begin
            t = addr_t'(v.rd1) + addr_t'(v.immext);
            t[0] = 1'b0;
        end else begin
            t = v.pc + addr_t'(v.immext);
        end
        return t;
    endfunction

    function automatic logic ref_redirect(input vec_t v);
        return v.jump || (v.branch && (v.rd1 == v.rd2));
    endfunction

    function automatic data_t pick_operand();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return {1'b1, {(`DATA_WIDTH-1){1'b0}}}; // most negative
            3'd3:    return {1'b0, {(`DATA_WIDTH-1){1'b1}}};
            default: return data_t'($random(seed));
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("FAIL at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
        $display("TEST FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) report_mismatch(what, 64'(got), 64'(exp));
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) report_mismatch(what, 64'(got), 64'(exp));
    endtask

    task automatic check_reg(input reg_addr_t got, input reg_addr_t exp, input string what);
        if (got !== exp) report_mismatch(what, 64'(got), 64'(exp));
    endtask

    task automatic check_src(input result_src_t got, input result_src_t exp, input string what);
        if (got !== exp) report_mismatch(what, 64'(got), 64'(exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) report_mismatch(what, 64'(got), 64'(exp));
    endtask

    task automatic drive_vector();
        logic [31:0] r;
        data_t       a;
        data_t       b;
        addr_t       pc;
        r  = $random(seed);
        a  = pick_operand();
        b  = pick_operand();
        pc = addr_t'($random(seed));
        pc[1:0] = 2'b00;
        if (r[0])
            b = a; // equal operands for half the branches
        regwrited   <= r[1];
        memwrited   <= r[2];
        resultsrcd  <= (r[4:3] == 2'd3) ? `RES_ALU : r[4:3];
        jumpd       <= (r[7:5] == 3'd0);
        branchd     <= r[8];
        jalrd       <= r[9];
        alucontrold <= r[12:10];
        alusrcd     <= r[13];
        rs1d        <= r[18:14];
        rs2d        <= r[23:19];
        rdd         <= r[28:24];
        rd1d        <= a;
        rd2d        <= b;
        immextd     <= pick_operand();
        pcd         <= pc;
        pcplus4d    <= pc + addr_t'(4);
        clr         <= (r[31:29] == 3'd0); // flush about one cycle in eight
    endtask

    task automatic drive_idle();
        regwrited   <= 1'b0;
        memwrited   <= 1'b0;
        jumpd       <= 1'b0;
        branchd     <= 1'b0;
        jalrd       <= 1'b0;
        clr         <= 1'b0;
    endtask

    // reference pipeline, two entries deep
    always @(posedge clk) begin
        vec_t item;
        if (!rst_n || clr)
            item = '0;
        else
            item = {regwrited, resultsrcd, memwrited, jumpd, branchd, alucontrold,
                    alusrcd, jalrd, rd1d, rd2d, pcd, rs1d, rs2d, rdd, immextd, pcplus4d};
        pipe.push_back(item);
        if (pipe.size() > 2)
            void'(pipe.pop_front());
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        vec_t e_item;
        vec_t m_item;
        e_item = pipe[1];
        m_item = pipe[0];
        check_reg(rs1e, e_item.rs1, "rs1e");
        check_reg(rs2e, e_item.rs2, "rs2e");
        check_reg(rde, e_item.rd, "rde");
        check_addr(pctargete, ref_target(e_item), "pctargete");
        check_bit(pcsrce, ref_redirect(e_item), "pcsrce");
        check_bit(regwritem, m_item.regwrite, "regwritem");
        check_bit(memwritem, m_item.memwrite, "memwritem");
        check_src(resultsrcm, m_item.resultsrc, "resultsrcm");
        check_reg(rdm, m_item.rd, "rdm");
        check_data(writedatam, m_item.rd2, "writedatam");
        check_addr(pcplus4m, m_item.pcplus4, "pcplus4m");
        check_data(aluresultm,
                   ref_alu(m_item.alucontrol, m_item.rd1,
                           m_item.alusrc ? m_item.immext : m_item.rd2),
                   "aluresultm");
        checks = checks + 1;
    end

    initial begin
        rst_n       = 1'b0;
        clr         = 1'b0;
        regwrited   = 1'b0;
        resultsrcd  = `RES_ALU;
        memwrited   = 1'b0;
        jumpd       = 1'b0;
        branchd     = 1'b0;
        alucontrold = `ALU_ADD;
        alusrcd     = 1'b0;
        jalrd       = 1'b0;
        rd1d        = '0;
        rd2d        = '0;
        pcd         = '0;
        rs1d        = '0;
        rs2d        = '0;
        rdd         = '0;
        immextd     = '0;
        pcplus4d    = '0;
        pipe.push_back('0);
        pipe.push_back('0);

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            drive_vector(); // back to back, no idle cycles
            @(posedge clk);
        end
        drive_idle();
        repeat (3) @(posedge clk);
        @(negedge clk);
        #(CLK_PERIOD / 4); // last compare done

        $display("%0d cycles compared", checks);
        $display("TEST PASS");
        $finish;
    end

    initial begin
        #((NUM_VECTORS + 20) * CLK_PERIOD);
        $display("watchdog expired before all vectors were checked");
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
logic/execute_pkg.sv
logic/pipeline_reg_execute.sv
logic/execute_alu.sv
logic/branch_resolve.sv
logic/pipeline_reg_memory.sv
logic/execute_stage.sv
dv/execute_stage_checker.sv
dv/execute_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := execute_stage_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
